//--- src/fpu_pkg.sv
package fpu_pkg;

   //////////////////////////////////////////////////
   // Field widths.
   //////////////////////////////////////////////////
   localparam int op_width   = 5;
   localparam int exp_width  = 8;
   localparam int frac_width = 23;
   localparam int exp_bias   = 127;

   //////////////////////////////////////////////////
   // Operation codes.
   //////////////////////////////////////////////////
   localparam logic [op_width-1:0] op_flw      = 5'd0;
   localparam logic [op_width-1:0] op_fsw      = 5'd1;
   localparam logic [op_width-1:0] op_fadd     = 5'd2;
   localparam logic [op_width-1:0] op_fsub     = 5'd3;
   localparam logic [op_width-1:0] op_fmul     = 5'd4;
   localparam logic [op_width-1:0] op_fsgnj    = 5'd5;
   localparam logic [op_width-1:0] op_fsgnjn   = 5'd6;
   localparam logic [op_width-1:0] op_fsgnjx   = 5'd7;
   localparam logic [op_width-1:0] op_feq      = 5'd8;
   localparam logic [op_width-1:0] op_flt      = 5'd9;
   localparam logic [op_width-1:0] op_fle      = 5'd10;
   localparam logic [op_width-1:0] op_fcvt_w_s = 5'd11;
   localparam logic [op_width-1:0] op_fcvt_s_w = 5'd12;
   localparam logic [op_width-1:0] op_fmv_x_w  = 5'd13;
   localparam logic [op_width-1:0] op_fmv_w_x  = 5'd14;

   typedef struct packed {
      logic                  sign;
      logic [exp_width-1:0]  exp;
      logic [frac_width-1:0] frac;
   } fp_fields_t;

   typedef union packed {
      logic [31:0] raw;
      fp_fields_t  fields;
   } fp_word_t;

   typedef struct packed {
      logic [op_width-1:0] op;
      logic signed [11:0]  imm;
   } fpu_instr_t;

   typedef struct packed {
      logic [31:0] rs1;
      logic [31:0] rs2;
   } reg_pair_t;

   // Leading zeros of a 32-bit word, 32 for an all-zero word.
   function automatic logic [5:0] count_lz32(input logic [31:0] v);
      logic [5:0] n;
      logic       found;
      n = 6'd0;
      found = 1'b0;
      for (int k = 31; k >= 0; k--) begin
         if (!found && v[k])
            found = 1'b1;
         else if (!found)
            n = n + 6'd1;
      end
      return n;
   endfunction

endpackage

//--- src/fpu_add.sv
`timescale 1ns/1ps

module fpu_add (
   input  fpu_pkg::fp_word_t a,
   input  fpu_pkg::fp_word_t b,
   input  logic              subtract,
   output fpu_pkg::fp_word_t sum
);
   import fpu_pkg::*;

   fp_word_t          a_in;
   fp_word_t          b_in;
   logic              a_big;
   fp_word_t          x;
   fp_word_t          y;
   logic [26:0]       mx;
   logic [26:0]       my;
   logic [7:0]        shift;
   logic [26:0]       my_shr;
   logic              sticky;
   logic [26:0]       aligned;
   logic [27:0]       s;
   logic [5:0]        lz;
   logic [27:0]       norm;
   logic              round_up;
   logic [24:0]       mant;
   logic signed [9:0] e;

   //////////////////////////////////////////////////
   // Operand preparation.
   //////////////////////////////////////////////////
   always_comb begin
      a_in = a;
      b_in = b;
      b_in.fields.sign = b.fields.sign ^ subtract;   // Subtract is add of negated b.
      if (a.fields.exp == '0)
         a_in.fields.frac = '0;                      // Flush denormal.
      if (b.fields.exp == '0)
         b_in.fields.frac = '0;
   end

   // x holds the larger magnitude.
   assign a_big = a_in.raw[30:0] >= b_in.raw[30:0];
   assign x     = a_big ? a_in : b_in;
   assign y     = a_big ? b_in : a_in;

   // Hidden bit, fraction, then guard, round and sticky.
   assign mx = {x.fields.exp != '0, x.fields.frac, 3'b000};
   assign my = {y.fields.exp != '0, y.fields.frac, 3'b000};

   //////////////////////////////////////////////////
   // Alignment and significand add.
   //////////////////////////////////////////////////
   assign shift   = x.fields.exp - y.fields.exp;
   assign my_shr  = my >> shift;
   assign sticky  = (my_shr << shift) != my;        // Any bit shifted out.
   assign aligned = {my_shr[26:1], my_shr[0] | sticky};

   assign s = (x.fields.sign == y.fields.sign) ? {1'b0, mx} + {1'b0, aligned}
                                               : {1'b0, mx} - {1'b0, aligned};

   //////////////////////////////////////////////////
   // Normalize and round.
   //////////////////////////////////////////////////
   assign lz   = count_lz32({s, 4'b0000});
   assign norm = s << lz;                           // Leading one to bit 27.

   // Nearest even on guard bit 3 with sticky below.
   assign round_up = norm[3] & ((|norm[2:0]) | norm[4]);
   assign mant     = {1'b0, norm[27:4]} + 25'(round_up);

   assign e = $signed({2'b00, x.fields.exp}) + 10'sd1 - $signed({4'b0000, lz})
              + $signed({9'd0, mant[24]});

   always_comb begin
      sum.raw = '0;
      if (s == '0) begin
         sum.fields.sign = x.fields.sign & y.fields.sign;   // -0 only from two negatives.
      end else if (e <= 0) begin
         sum.fields.sign = x.fields.sign;                   // Underflow to signed zero.
      end else if (e >= 255) begin
         sum.fields.sign = x.fields.sign;
         sum.fields.exp  = '1;                              // Infinity.
      end else begin
         sum.fields.sign = x.fields.sign;
         sum.fields.exp  = e[7:0];
         sum.fields.frac = mant[22:0];                      // Zero after a carry out.
      end
   end

endmodule

//--- src/fpu_mul.sv
`timescale 1ns/1ps

module fpu_mul (
   input  fpu_pkg::fp_word_t a,
   input  fpu_pkg::fp_word_t b,
   output fpu_pkg::fp_word_t product
);
   import fpu_pkg::*;

   logic              sign;
   logic              zero_in;
   logic [47:0]       p;
   logic [47:0]       pn;
   logic              round_up;
   logic [24:0]       mant;
   logic signed [9:0] e;

   assign sign    = a.fields.sign ^ b.fields.sign;
   assign zero_in = (a.fields.exp == '0) || (b.fields.exp == '0);   // Zero or denormal.

   //////////////////////////////////////////////////
   // Significand product.
   //////////////////////////////////////////////////
   assign p  = {1'b1, a.fields.frac} * {1'b1, b.fields.frac};
   assign pn = p[47] ? p : {p[46:0], 1'b0};         // Leading one to bit 47.

   // Nearest even on bit 23.
   assign round_up = pn[23] & ((|pn[22:0]) | pn[24]);
   assign mant     = {1'b0, pn[47:24]} + 25'(round_up);

   assign e = $signed({2'b00, a.fields.exp}) + $signed({2'b00, b.fields.exp})
              - 10'(exp_bias) + $signed({9'd0, p[47]}) + $signed({9'd0, mant[24]});

   always_comb begin
      product.raw = '0;
      product.fields.sign = sign;
      if (zero_in || e <= 0) begin
         product.fields.exp = '0;                   // Signed zero.
      end else if (e >= 255) begin
         product.fields.exp = '1;                   // Infinity.
      end else begin
         product.fields.exp  = e[7:0];
         product.fields.frac = mant[22:0];
      end
   end

endmodule

//--- src/fpu_sign_compare.sv
`timescale 1ns/1ps

module fpu_sign_compare (
   input  logic [fpu_pkg::op_width-1:0] op,
   input  fpu_pkg::fp_word_t            a,
   input  fpu_pkg::fp_word_t            b,
   output logic [31:0]                  y
);
   import fpu_pkg::*;

   logic [30:0] mag_a;
   logic [30:0] mag_b;
   logic        both_zero;
   logic        eq;
   logic        lt;
   logic        inj_sign;

   //////////////////////////////////////////////////
   // Comparisons.
   //////////////////////////////////////////////////
   assign mag_a = (a.fields.exp == '0) ? '0 : a.raw[30:0];   // Denormal compares as zero.
   assign mag_b = (b.fields.exp == '0) ? '0 : b.raw[30:0];

   assign both_zero = (mag_a == '0) && (mag_b == '0);
   assign eq = both_zero || ((a.fields.sign == b.fields.sign) && (mag_a == mag_b));

   always_comb begin
      if (both_zero)
         lt = 1'b0;                                 // +0 equals -0.
      else if (a.fields.sign != b.fields.sign)
         lt = a.fields.sign;
      else if (a.fields.sign)
         lt = mag_a > mag_b;                        // Negatives order reversed.
      else
         lt = mag_a < mag_b;
   end

   //////////////////////////////////////////////////
   // Sign injection.
   //////////////////////////////////////////////////
   always_comb begin
      case (op)
         op_fsgnjn: inj_sign = ~b.fields.sign;
         op_fsgnjx: inj_sign = a.fields.sign ^ b.fields.sign;
         default:   inj_sign = b.fields.sign;
      endcase
   end

   always_comb begin
      case (op)
         op_fsgnj, op_fsgnjn, op_fsgnjx: y = {inj_sign, a.raw[30:0]};
         op_feq:                         y = {31'd0, eq};
         op_flt:                         y = {31'd0, lt};
         op_fle:                         y = {31'd0, lt | eq};
         default:                        y = '0;
      endcase
   end

endmodule

//--- src/fpu_convert.sv
`timescale 1ns/1ps

module fpu_convert (
   input  logic [fpu_pkg::op_width-1:0] op,
   input  fpu_pkg::fp_word_t            f,
   input  logic signed [31:0]           i,
   output logic [31:0]                  y
);
   import fpu_pkg::*;

   logic [7:0]  shamt;
   logic [63:0] fixed;
   logic        f_round;
   logic [31:0] f_mag;
   logic [31:0] to_int;
   logic        i_sign;
   logic [31:0] i_mag;
   logic [5:0]  i_lz;
   logic [31:0] i_norm;
   logic        i_round;
   logic [24:0] i_mant;
   logic [7:0]  i_exp;
   fp_word_t    to_float;

   //////////////////////////////////////////////////
   // Float to integer.
   //////////////////////////////////////////////////
   // Significand placed in 32.32 fixed point.
   assign shamt = f.fields.exp - 8'(exp_bias - 9);
   assign fixed = {40'd0, 1'b1, f.fields.frac} << shamt;

   assign f_round = fixed[31] & ((|fixed[30:0]) | fixed[32]);
   assign f_mag   = fixed[63:32] + 32'(f_round);   // Below 2**31 in range.

   always_comb begin
      if (f.fields.exp < 8'(exp_bias - 1)) begin
         to_int = '0;                               // Below one half, or denormal.
      end else if (f.fields.exp >= 8'(exp_bias + 31)) begin
         to_int = f.fields.sign ? 32'h8000_0000 : 32'h7fff_ffff;
      end else if (f.fields.sign) begin
         to_int = -f_mag;
      end else begin
         to_int = f_mag;
      end
   end

   //////////////////////////////////////////////////
   // Integer to float.
   //////////////////////////////////////////////////
   assign i_sign = i[31];
   assign i_mag  = i_sign ? -i : i;
   assign i_lz   = count_lz32(i_mag);
   assign i_norm = i_mag << i_lz;

   // Keep 24 bits, round on bit 7.
   assign i_round = i_norm[7] & ((|i_norm[6:0]) | i_norm[8]);
   assign i_mant  = {1'b0, i_norm[31:8]} + 25'(i_round);
   assign i_exp   = 8'(exp_bias + 31) - 8'(i_lz) + 8'(i_mant[24]);

   always_comb begin
      to_float.raw = '0;
      if (i_mag != '0) begin
         to_float.fields.sign = i_sign;
         to_float.fields.exp  = i_exp;
         to_float.fields.frac = i_mant[22:0];
      end
   end

   always_comb begin
      case (op)
         op_fcvt_w_s: y = to_int;
         op_fcvt_s_w: y = to_float.raw;
         default:     y = '0;
      endcase
   end

endmodule

//--- src/fpu.sv
`timescale 1ns/1ps

module fpu (
   input  logic                clk,
   input  logic                reset,
   input  logic                issue,
   input  fpu_pkg::fpu_instr_t instr,
   input  fpu_pkg::reg_pair_t  int_regs,
   input  fpu_pkg::reg_pair_t  fp_regs,
   output logic                completed,
   output logic [31:0]         result
);
   import fpu_pkg::*;

   fp_word_t    fa;
   fp_word_t    fb;
   fp_word_t    add_y;
   fp_word_t    mul_y;
   logic [31:0] sgn_cmp_y;
   logic [31:0] cvt_y;
   logic [31:0] addr;
   logic [31:0] next_result;

   assign fa = fp_regs.rs1;
   assign fb = fp_regs.rs2;

   //////////////////////////////////////////////////
   // Execution units.
   //////////////////////////////////////////////////
   fpu_add u_add (
      .a        (fa),
      .b        (fb),
      .subtract (instr.op == op_fsub),
      .sum      (add_y)
   );

   fpu_mul u_mul (
      .a       (fa),
      .b       (fb),
      .product (mul_y)
   );

   fpu_sign_compare u_sign_compare (
      .op (instr.op),
      .a  (fa),
      .b  (fb),
      .y  (sgn_cmp_y)
   );

   fpu_convert u_convert (
      .op (instr.op),
      .f  (fa),
      .i  (int_regs.rs1),
      .y  (cvt_y)
   );

   // Load and store effective address.
   assign addr = int_regs.rs1 + {{20{instr.imm[11]}}, instr.imm};

   always_comb begin
      case (instr.op)
         op_flw, op_fsw:                 next_result = addr;
         op_fadd, op_fsub:               next_result = add_y.raw;
         op_fmul:                        next_result = mul_y.raw;
         op_fsgnj, op_fsgnjn, op_fsgnjx,
         op_feq, op_flt, op_fle:         next_result = sgn_cmp_y;
         op_fcvt_w_s, op_fcvt_s_w:       next_result = cvt_y;
         op_fmv_x_w:                     next_result = fp_regs.rs1;
         op_fmv_w_x:                     next_result = int_regs.rs1;
         default:                        next_result = '0;   // Unknown op completes as zero.
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         completed <= 1'b0;
         result    <= '0;
      end else begin
         completed <= issue;
         if (issue)
            result <= next_result;                   // Holds between issues.
      end
   end

endmodule

//--- verification/fpu_tb.sv
`timescale 1ns/1ps

module fpu_tb;
   import fpu_pkg::*;

   localparam int max_vectors    = 64;
   localparam int timeout_cycles = 20;
   localparam int burst_len      = 16;

   logic        clk = 1'b0;
   logic        reset;
   logic        issue;
   fpu_instr_t  instr;
   reg_pair_t   int_regs;
   reg_pair_t   fp_regs;
   logic        completed;
   logic [31:0] result;

   logic [4:0]  vec_op  [max_vectors];
   logic [11:0] vec_imm [max_vectors];
   logic [31:0] vec_int [max_vectors];
   logic [31:0] vec_fa  [max_vectors];
   logic [31:0] vec_fb  [max_vectors];
   logic [31:0] vec_exp [max_vectors];
   int          vec_count    = 0;
   int          errors       = 0;
   int          burst_issued = 0;
   int          seed         = 32'h9d2e31a5;
   logic [31:0] exp_q [$];            // Expected results still in flight.
   int          idx_q [$];

   fpu u_dut (
      .clk       (clk),
      .reset     (reset),
      .issue     (issue),
      .instr     (instr),
      .int_regs  (int_regs),
      .fp_regs   (fp_regs),
      .completed (completed),
      .result    (result)
   );

   always #4 clk = ~clk;

   //////////////////////////////////////////////////
   // Helpers.
   //////////////////////////////////////////////////
   task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                              input string what, input int index);
      if (got !== expected) begin
         $display("ERR %0t ns: %s mismatch on vector %0d, got %h expected %h",
                  $time, what, index, got, expected);
         errors++;
      end
   endtask

   task automatic load_vectors();
      int          fd;
      string       line;
      logic [4:0]  op;
      logic [11:0] imm;
      logic [31:0] ir;
      logic [31:0] fa;
      logic [31:0] fb;
      logic [31:0] ex;
      fd = $fopen("verification/fpu_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file verification/fpu_stimulus.txt.");
         errors++;
         return;
      end
      while (!$feof(fd) && vec_count < max_vectors) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 0 && line[0] != "#") begin
            if ($sscanf(line, "%h %h %h %h %h %h", op, imm, ir, fa, fb, ex) == 6) begin
               vec_op[vec_count]  = op;
               vec_imm[vec_count] = imm;
               vec_int[vec_count] = ir;
               vec_fa[vec_count]  = fa;
               vec_fb[vec_count]  = fb;
               vec_exp[vec_count] = ex;
               vec_count++;
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic drive_vector(input int n);
      instr.op     = vec_op[n];
      instr.imm    = vec_imm[n];
      int_regs.rs1 = vec_int[n];
      int_regs.rs2 = '0;
      fp_regs.rs1  = vec_fa[n];
      fp_regs.rs2  = vec_fb[n];
      issue        = 1'b1;
   endtask

   // One vector, then an idle cycle to see completed drop and result hold.
   task automatic run_directed(input int n);
      int cycles;
      cycles = 0;
      drive_vector(n);
      do begin
         @(posedge clk);
         #1;
         issue = 1'b0;
         cycles++;
      end while (!completed && cycles < timeout_cycles);
      // Idle inputs that would give another result if loaded.
      instr.op     = op_fmv_w_x;
      int_regs.rs1 = ~vec_exp[n];
      if (!completed) begin
         $display("Timeout: vector %0d did not complete within %0d cycles.", n, timeout_cycles);
         errors++;
      end else begin
         check_value(32'(cycles), 32'd1, "latency", n);
         check_value(result, vec_exp[n], "result", n);
         @(posedge clk);
         #1;
         check_value({31'd0, completed}, 32'd0, "idle completion", n);
         check_value(result, vec_exp[n], "held result", n);
      end
   endtask

   task automatic collect_completion();
      int n;
      if (completed) begin
         if (exp_q.size() == 0) begin
            $display("Unexpected completion at %0t ns with nothing issued.", $time);
            errors++;
         end else begin
            n = idx_q.pop_front();
            check_value(result, exp_q.pop_front(), "burst result", n);
         end
      end
   endtask

   // Back to back issues in a random order.
   task automatic run_burst();
      int idx;
      for (int k = 0; k < burst_len; k++) begin
         idx = $unsigned($random(seed)) % vec_count;
         drive_vector(idx);
         exp_q.push_back(vec_exp[idx]);
         idx_q.push_back(idx);
         burst_issued++;
         @(posedge clk);
         #1;
         collect_completion();
         if (exp_q.size() != 0) begin
            $display("Vector %0d in the burst did not complete on the next cycle.", idx);
            errors++;
            exp_q.delete();
            idx_q.delete();
         end
      end
      issue = 1'b0;
      @(posedge clk);
      #1;
      check_value({31'd0, completed}, 32'd0, "completion after burst", -1);
   endtask

   //////////////////////////////////////////////////
   // Main sequence.
   //////////////////////////////////////////////////
   initial begin
      reset    = 1'b1;
      issue    = 1'b0;
      instr    = '0;
      int_regs = '0;
      fp_regs  = '0;
      load_vectors();
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      check_value({31'd0, completed}, 32'd0, "completed after reset", -1);
      check_value(result, 32'd0, "result after reset", -1);
      if (vec_count > 0) begin
         for (int n = 0; n < vec_count; n++)
            run_directed(n);
         run_burst();
      end else if (errors == 0) begin
         $display("The stimulus file holds no vectors.");
         errors++;
      end
      $display("fpu_tb: %0d vectors, %0d burst issues, %0d errors.",
               vec_count, burst_issued, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- verification/fpu_stimulus.txt
# op imm int_rs1 fp_rs1 fp_rs2 expected
# All fields in hex, unused operands are zero.
00 010 00001000 00000000 00000000 00001010
00 ffc 00002000 00000000 00000000 00001ffc
01 7ff 10000000 00000000 00000000 100007ff
01 800 00000100 00000000 00000000 fffff900
02 000 00000000 3f800000 40000000 40400000
02 000 00000000 40400000 bf800000 40000000
02 000 00000000 bf800000 c0000000 c0400000
02 000 00000000 3f800000 bf800000 00000000
02 000 00000000 80000000 80000000 80000000
02 000 00000000 3f800000 33800000 3f800000
02 000 00000000 3f800001 33800000 3f800002
02 000 00000000 7f7fffff 7f7fffff 7f800000
02 000 00000000 ff7fffff ff7fffff ff800000
02 000 00000000 80c00000 00800000 80000000
03 000 00000000 40000000 40000000 00000000
03 000 00000000 3f800000 40400000 c0000000
03 000 00000000 00c00000 00800000 00000000
04 000 00000000 40000000 40400000 40c00000
04 000 00000000 bfc00000 40000000 c0400000
04 000 00000000 3fc00000 3f800001 3fc00002
04 000 00000000 3fc00000 3f800003 3fc00004
04 000 00000000 7f000000 40000000 7f800000
04 000 00000000 80800000 3f000000 80000000
04 000 00000000 80000000 40400000 80000000
05 000 00000000 40400000 bf800000 c0400000
06 000 00000000 40400000 bf800000 40400000
07 000 00000000 c0400000 bf800000 40400000
07 000 00000000 40400000 bf800000 c0400000
08 000 00000000 00000000 80000000 00000001
08 000 00000000 3f800000 40000000 00000000
09 000 00000000 c0000000 bf800000 00000001
09 000 00000000 bf800000 c0000000 00000000
09 000 00000000 00000000 80000000 00000000
0a 000 00000000 80000000 00000000 00000001
0a 000 00000000 40000000 3f800000 00000000
0a 000 00000000 c0000000 c0000000 00000001
0b 000 00000000 40200000 00000000 00000002
0b 000 00000000 c0200000 00000000 fffffffe
0b 000 00000000 bfc00000 00000000 fffffffe
0b 000 00000000 3f000000 00000000 00000000
0b 000 00000000 c2f60000 00000000 ffffff85
0b 000 00000000 4f000000 00000000 7fffffff
0b 000 00000000 cf800000 00000000 80000000
0c 000 00000000 00000000 00000000 00000000
0c 000 ffffff85 00000000 00000000 c2f60000
0c 000 01000001 00000000 00000000 4b800000
0c 000 01000003 00000000 00000000 4b800002
0c 000 7fffffff 00000000 00000000 4f000000
0d 000 12345678 c0490fdb 00000000 c0490fdb
0e 000 3f800000 deadbeef 00000000 3f800000
1f 000 12345678 3f800000 40000000 00000000

//--- tb.f
src/fpu_pkg.sv
src/fpu_add.sv
src/fpu_mul.sv
src/fpu_sign_compare.sv
src/fpu_convert.sv
src/fpu.sv
verification/fpu_tb.sv

//--- Bender.yml
package:
  name: fpu

sources:
  - src/fpu_pkg.sv
  - src/fpu_add.sv
  - src/fpu_mul.sv
  - src/fpu_sign_compare.sv
  - src/fpu_convert.sv
  - src/fpu.sv
  - target: simulation
    files:
      - verification/fpu_tb.sv
